/* dv/tb_reg_hub.sv */
/*
 * Testbench for the shared register hub
 * Competing managers, random back-pressure and a register model
 * that predicts every response and read value
 */

`timescale 1ns/1ns

module tb_reg_hub import axil_pkg::*, regmap_pkg::*; ();

  localparam int NUM_MASTERS = 3;
  localparam int NUM_REGS    = 12;
  localparam int N_RANDOM    = 40;
  // Transactions per test, summed for the watchdog
  localparam int TOTAL_TXNS  = 6 + 3 + 5 + 4 + 2 + NUM_MASTERS * N_RANDOM;
  localparam int CYCLES_PER_TXN = 200;

  logic                         clk;
  logic                         rst_n;
  logic       [NUM_MASTERS-1:0] awvalid, awready, wvalid, wready, bvalid, bready;
  logic       [NUM_MASTERS-1:0] arvalid, arready, rvalid, rready;
  axil_addr_t [NUM_MASTERS-1:0] awaddr, araddr;
  axil_data_t [NUM_MASTERS-1:0] wdata, rdata;
  axil_strb_t [NUM_MASTERS-1:0] wstrb;
  axil_resp_e [NUM_MASTERS-1:0] bresp, rresp;

  // Outstanding transaction per manager, for the channel monitor
  logic       [NUM_MASTERS-1:0] wr_busy, rd_busy;
  axil_data_t model [0:15];
  int         b_order [$];
  integer     seed = 32'hd3e;

  reg_hub_top #(
    .NUM_MASTERS(NUM_MASTERS),
    .NUM_REGS   (NUM_REGS)
  ) dut0 (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  always #5 clk = ~clk;

  // --------------------
  // Reporting and checks
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
    if (exp != act) begin
      abort_run($sformatf("error %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
    if (exp != act) begin
      abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic int index_of(input axil_addr_t addr);
    return int'(addr[REG_IDX_LSB +: REG_IDX_W]);
  endfunction

  function automatic axil_addr_t reg_addr(input int idx);
    return axil_addr_t'(idx) << REG_IDX_LSB;
  endfunction

  // Read value or merged write value, with the response code
  function automatic void predict(input logic is_write, input axil_addr_t addr,
                                  input axil_data_t data, input axil_strb_t strb,
                                  output axil_data_t exp_data, output axil_resp_e exp_resp);
    int   idx;
    logic mapped;
    idx = index_of(addr);
    mapped = (addr[AXIL_ADDR_W-1:REG_IDX_LSB+REG_IDX_W] == '0) && (idx < NUM_REGS);
    exp_data = '0;
    exp_resp = SLVERR;
    if (mapped && idx == 0 && !is_write) begin
      exp_data = ID_VALUE;
      exp_resp = OKAY;
    end else if (mapped && idx != 0) begin
      exp_data = model[idx];
      exp_resp = OKAY;
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (is_write && strb[b]) exp_data[8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  // Ready high three times out of four
  function automatic logic ready_draw();
    return ($random(seed) & 3) != 0;
  endfunction

  // --------------------
  // Manager drivers
  // --------------------
  task automatic write_txn(input int m, input string name, input axil_addr_t addr,
                           input axil_data_t data, input axil_strb_t strb,
                           output axil_resp_e resp);
    axil_data_t exp_data;
    axil_resp_e exp_resp;
    @(negedge clk);
    wr_busy[m] = 1'b1;
    awvalid[m] = 1'b1;
    wvalid[m]  = 1'b1;
    awaddr[m]  = addr;
    wdata[m]   = data;
    wstrb[m]   = strb;
    @(posedge clk);
    while (!(awready[m] && wready[m])) @(posedge clk);
    @(negedge clk);
    awvalid[m] = 1'b0;
    wvalid[m]  = 1'b0;
    bready[m]  = ready_draw();
    @(posedge clk);
    while (!(bvalid[m] && bready[m])) begin
      @(negedge clk);
      bready[m] = ready_draw();
      @(posedge clk);
    end
    resp = bresp[m];
    predict(1'b1, addr, data, strb, exp_data, exp_resp);
    check_resp(name, exp_resp, resp);
    // Model follows the order of the b handshakes
    if (exp_resp == OKAY) model[index_of(addr)] = exp_data;
    b_order.push_back(m);
    @(negedge clk);
    bready[m]  = 1'b0;
    wr_busy[m] = 1'b0;
  endtask

  task automatic read_txn(input int m, input string name, input axil_addr_t addr,
                          output axil_data_t data, output axil_resp_e resp);
    axil_data_t exp_data;
    axil_resp_e exp_resp;
    @(negedge clk);
    rd_busy[m] = 1'b1;
    arvalid[m] = 1'b1;
    araddr[m]  = addr;
    @(posedge clk);
    while (!arready[m]) @(posedge clk);
    @(negedge clk);
    arvalid[m] = 1'b0;
    rready[m]  = ready_draw();
    @(posedge clk);
    while (!(rvalid[m] && rready[m])) begin
      @(negedge clk);
      rready[m] = ready_draw();
      @(posedge clk);
    end
    data = rdata[m];
    resp = rresp[m];
    predict(1'b0, addr, '0, '0, exp_data, exp_resp);
    check_resp(name, exp_resp, resp);
    check_data(name, exp_data, data);
    @(negedge clk);
    rready[m]  = 1'b0;
    rd_busy[m] = 1'b0;
  endtask

  // Mixed traffic, indexes past the map and out-of-map addresses included
  task automatic random_traffic(input int m, input int count);
    axil_addr_t addr;
    axil_data_t data;
    axil_resp_e resp;
    for (int n = 0; n < count; n++) begin
      addr = reg_addr($unsigned($random(seed)) % 16);
      if (($random(seed) & 15) == 0) addr[8] = 1'b1;
      if ($random(seed) & 1) begin
        write_txn(m, "t6 random write", addr, $random(seed), axil_strb_t'($random(seed)), resp);
      end else begin
        read_txn(m, "t6 random read", addr, data, resp);
      end
      repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    end
  endtask

  // --------------------
  // Channel monitor and watchdog
  // --------------------
  always @(posedge clk) begin
    if (rst_n) begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if ((awready[m] && !awvalid[m]) || (wready[m] && !wvalid[m]))
          abort_run($sformatf("manager %0d saw a write ready without valid", m));
        if (arready[m] && !arvalid[m])
          abort_run($sformatf("manager %0d saw arready without arvalid", m));
        if ((bvalid[m] && !wr_busy[m]) || (rvalid[m] && !rd_busy[m]))
          abort_run($sformatf("manager %0d got a response it never asked for", m));
      end
    end
  end

  initial begin
    repeat (4 + CYCLES_PER_TXN * TOTAL_TXNS) @(posedge clk);
    abort_run("simulation hung waiting for a response");
  end

  // --------------------
  // Tests
  // --------------------
  initial begin
    axil_data_t rd;
    axil_data_t rd5;
    axil_resp_e rs;
    axil_resp_e r0;
    axil_resp_e r1;
    axil_resp_e r2;
    clk = 1'b0;
    rst_n = 1'b0;
    awvalid = '0;
    wvalid = '0;
    bready = '0;
    arvalid = '0;
    rready = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    wr_busy = '0;
    rd_busy = '0;
    for (int k = 0; k < 16; k++) model[k] = REG_RESET;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Full and partial strobes on one register
    write_txn(0, "t1 full write", reg_addr(3), 32'ha5a5_1234, 4'hf, rs);
    read_txn(0, "t1 full read", reg_addr(3), rd, rs);
    write_txn(0, "t1 mid bytes", reg_addr(3), 32'h00ff_ee00, 4'b0110, rs);
    read_txn(0, "t1 mid read", reg_addr(3), rd, rs);
    write_txn(0, "t1 end bytes", reg_addr(3), 32'h7700_0099, 4'b1001, rs);
    read_txn(0, "t1 end read", reg_addr(3), rd, rs);

    // ID word is read-only
    read_txn(1, "t2 id read", reg_addr(0), rd, rs);
    check_data("t2 id value", ID_VALUE, rd);
    write_txn(1, "t2 id write", reg_addr(0), 32'hdead_beef, 4'hf, rs);
    check_resp("t2 id write resp", SLVERR, rs);
    read_txn(1, "t2 id reread", reg_addr(0), rd, rs);
    check_data("t2 id unchanged", ID_VALUE, rd);

    // Unimplemented and out-of-map accesses
    write_txn(2, "t3 write past map", reg_addr(NUM_REGS), 32'h1234_5678, 4'hf, rs);
    check_resp("t3 write past map resp", SLVERR, rs);
    read_txn(2, "t3 read past map", reg_addr(NUM_REGS), rd, rs);
    check_data("t3 read past map data", '0, rd);
    read_txn(2, "t3 read top index", reg_addr(15), rd, rs);
    write_txn(2, "t3 write high addr", 32'h0000_0104, 32'hcafe_f00d, 4'hf, rs);
    check_resp("t3 write high addr resp", SLVERR, rs);
    read_txn(2, "t3 read high addr", 32'h0000_0104, rd, rs);
    check_data("t3 read high addr data", '0, rd);

    // Same-cycle writes, granted lowest index first
    b_order.delete();
    fork
      write_txn(0, "t4 write m0", reg_addr(5), 32'h0000_aaa0, 4'hf, r0);
      write_txn(1, "t4 write m1", reg_addr(5), 32'h0000_bbb1, 4'hf, r1);
      write_txn(2, "t4 write m2", reg_addr(5), 32'h0000_ccc2, 4'hf, r2);
    join
    if (b_order.size() != NUM_MASTERS) abort_run("wrong number of write responses in test 4");
    for (int i = 0; i < NUM_MASTERS; i++) begin
      check_data("t4 grant order", axil_data_t'(i), axil_data_t'(b_order[i]));
    end
    read_txn(0, "t4 readback", reg_addr(5), rd, rs);
    check_data("t4 last writer wins", 32'h0000_ccc2, rd);

    // Write before read from one manager
    fork
      write_txn(1, "t5 write", reg_addr(7), 32'h0bad_cafe, 4'hf, rs);
      read_txn(1, "t5 read", reg_addr(7), rd5, r1);
    join
    check_data("t5 read sees write", 32'h0bad_cafe, rd5);

    // Random mixed traffic from every manager
    fork
      random_traffic(0, N_RANDOM);
      random_traffic(1, N_RANDOM);
      random_traffic(2, N_RANDOM);
    join

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the register hub testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_reg_hub -o tb_reg_hub

# Simulator status is ignored here, the log holds the verdict
./obj_dir/tb_reg_hub > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

/* src.f */
src/axil_pkg.sv
src/regmap_pkg.sv
src/arb_fixed.sv
src/axil_arb_mux.sv
src/reg_bank.sv
src/reg_hub_top.sv
dv/tb_reg_hub.sv

/* src/arb_fixed.sv */
/*
 * Fixed-priority arbiter
 * Grants at most one request per cycle, lowest index first
 * Enable low forces the grant to zero
 */

`timescale 1ns/1ns

module arb_fixed #(
  // At least 2
  parameter int NUM_MASTERS = 3
) (
  input  logic                   enable,
  input  logic [NUM_MASTERS-1:0] request,
  output logic [NUM_MASTERS-1:0] grant
);

  // --------------------
  // Priority scan
  // --------------------
  logic [NUM_MASTERS-1:0] grant_raw;
  logic                   found;

  // Walk up from index 0, first set bit wins
  always_comb begin
    grant_raw = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (request[i] && !found) begin
        grant_raw[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // --------------------
  // Enable mask
  // --------------------
  // No grant leaves the arbiter while disabled
  assign grant = {NUM_MASTERS{enable}} & grant_raw;

endmodule

/* src/axil_arb_mux.sv */
/*
 * AXI4-Lite interconnect, N managers onto one subordinate
 * Fixed-priority arbitration while idle, then the winner owns the
 * port for one full write or read transaction
 */

`timescale 1ns/1ns

module axil_arb_mux import axil_pkg::*; #(
  parameter int NUM_MASTERS = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // Manager side
  input  logic       [NUM_MASTERS-1:0]       awvalid,
  output logic       [NUM_MASTERS-1:0]       awready,
  input  axil_addr_t [NUM_MASTERS-1:0]       awaddr,
  input  logic       [NUM_MASTERS-1:0]       wvalid,
  output logic       [NUM_MASTERS-1:0]       wready,
  input  axil_data_t [NUM_MASTERS-1:0]       wdata,
  input  axil_strb_t [NUM_MASTERS-1:0]       wstrb,
  output logic       [NUM_MASTERS-1:0]       bvalid,
  input  logic       [NUM_MASTERS-1:0]       bready,
  output axil_resp_e [NUM_MASTERS-1:0]       bresp,
  input  logic       [NUM_MASTERS-1:0]       arvalid,
  output logic       [NUM_MASTERS-1:0]       arready,
  input  axil_addr_t [NUM_MASTERS-1:0]       araddr,
  output logic       [NUM_MASTERS-1:0]       rvalid,
  input  logic       [NUM_MASTERS-1:0]       rready,
  output axil_data_t [NUM_MASTERS-1:0]       rdata,
  output axil_resp_e [NUM_MASTERS-1:0]       rresp,
  // Subordinate side
  output logic                               s_awvalid,
  input  logic                               s_awready,
  output axil_addr_t                         s_awaddr,
  output logic                               s_wvalid,
  input  logic                               s_wready,
  output axil_data_t                         s_wdata,
  output axil_strb_t                         s_wstrb,
  input  logic                               s_bvalid,
  output logic                               s_bready,
  input  axil_resp_e                         s_bresp,
  output logic                               s_arvalid,
  input  logic                               s_arready,
  output axil_addr_t                         s_araddr,
  input  logic                               s_rvalid,
  output logic                               s_rready,
  input  axil_data_t                         s_rdata,
  input  axil_resp_e                         s_rresp
);

  localparam int OWNER_W = $clog2(NUM_MASTERS);

  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR,
    WR_RESP,
    RD_ADDR,
    RD_DATA
  } state_e;

  state_e               state;
  logic [OWNER_W-1:0]   owner;
  logic [OWNER_W-1:0]   grant_idx;
  logic [NUM_MASTERS-1:0] request;
  logic [NUM_MASTERS-1:0] grant;

  // --------------------
  // Arbitration
  // --------------------
  // Either channel asks for the port
  assign request = awvalid | arvalid;

  // Only a new grant while idle
  arb_fixed #(
    .NUM_MASTERS(NUM_MASTERS)
  ) u_arb (
    .enable  (state == IDLE),
    .request (request),
    .grant   (grant)
  );

  // One-hot grant to index
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (grant[i]) begin
        grant_idx = OWNER_W'(i);
      end
    end
  end

  // --------------------
  // Transaction FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      owner <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (|grant) begin
            owner <= grant_idx;
            // Write goes first when both are pending
            state <= awvalid[grant_idx] ? WR_ADDR : RD_ADDR;
          end
        end
        // Address and data are accepted in the same cycle
        WR_ADDR: if (s_awvalid && s_awready) state <= WR_RESP;
        WR_RESP: if (s_bvalid && s_bready) state <= IDLE;
        RD_ADDR: if (s_arvalid && s_arready) state <= RD_DATA;
        RD_DATA: if (s_rvalid && s_rready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // Owner to subordinate
  // --------------------
  assign s_awvalid = (state == WR_ADDR) && awvalid[owner];
  assign s_wvalid  = (state == WR_ADDR) && wvalid[owner];
  assign s_awaddr  = awaddr[owner];
  assign s_wdata   = wdata[owner];
  assign s_wstrb   = wstrb[owner];
  assign s_bready  = (state == WR_RESP) && bready[owner];
  assign s_arvalid = (state == RD_ADDR) && arvalid[owner];
  assign s_araddr  = araddr[owner];
  assign s_rready  = (state == RD_DATA) && rready[owner];

  // --------------------
  // Subordinate to managers
  // --------------------
  // Handshakes only reach the owner, payload is broadcast
  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      awready[i] = 1'b0;
      wready[i]  = 1'b0;
      bvalid[i]  = 1'b0;
      arready[i] = 1'b0;
      rvalid[i]  = 1'b0;
      if (owner == OWNER_W'(i)) begin
        awready[i] = (state == WR_ADDR) && s_awready;
        wready[i]  = (state == WR_ADDR) && s_wready;
        bvalid[i]  = (state == WR_RESP) && s_bvalid;
        arready[i] = (state == RD_ADDR) && s_arready;
        rvalid[i]  = (state == RD_DATA) && s_rvalid;
      end
      bresp[i] = s_bresp;
      rdata[i] = s_rdata;
      rresp[i] = s_rresp;
    end
  end

endmodule

/* src/axil_pkg.sv */
/*
 * AXI4-Lite common definitions
 * Bus widths, payload types and the response code used on every port
 */

package axil_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  // One strobe bit per data byte
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // --------------------
  // Payload types
  // --------------------
  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

  // Response codes, only the two this subsystem returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

endpackage

/* src/reg_bank.sv */
/*
 * AXI4-Lite register bank
 * Byte-strobed registers, read-only ID word at index 0,
 * SLVERR for writes to the ID word and for unmapped indexes
 */

`timescale 1ns/1ns

module reg_bank import axil_pkg::*, regmap_pkg::*; #(
  // At most 16
  parameter int NUM_REGS = 12
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       awvalid,
  output logic       awready,
  input  axil_addr_t awaddr,
  input  logic       wvalid,
  output logic       wready,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  output logic       bvalid,
  input  logic       bready,
  output axil_resp_e bresp,
  input  logic       arvalid,
  output logic       arready,
  input  axil_addr_t araddr,
  output logic       rvalid,
  input  logic       rready,
  output axil_data_t rdata,
  output axil_resp_e rresp
);

  // Index 0 is the ID word, not stored
  axil_data_t regs [1:NUM_REGS-1];

  reg_idx_t   wr_idx;
  reg_idx_t   rd_idx;
  logic       wr_fire;
  logic       wr_ok;
  logic       rd_fire;
  axil_data_t rd_word;
  axil_resp_e rd_code;

  // --------------------
  // Write channel
  // --------------------
  // Accept address and data together, one response at a time
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_fire = awready;

  assign wr_idx = addr_idx(awaddr);
  // ID word and unmapped indexes are not writable
  assign wr_ok  = addr_in_map(awaddr) && (wr_idx != '0) && (wr_idx < NUM_REGS);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 1; k < NUM_REGS; k++) begin
        regs[k] <= REG_RESET;
      end
    end else if (wr_fire && wr_ok) begin
      // Merge only the strobed bytes
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wstrb[b]) begin
          regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? OKAY : SLVERR;
    end
  end

  // --------------------
  // Read channel
  // --------------------
  assign arready = arvalid && !rvalid;
  assign rd_fire = arready;
  assign rd_idx  = addr_idx(araddr);

  // Decode of the read address
  always_comb begin
    if (!addr_in_map(araddr) || (rd_idx >= NUM_REGS)) begin
      rd_word = '0;
      rd_code = SLVERR;
    end else if (rd_idx == '0) begin
      rd_word = ID_VALUE;
      rd_code = OKAY;
    end else begin
      rd_word = regs[rd_idx];
      rd_code = OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read payload captured with the address handshake
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_code;
    end
  end

endmodule

/* src/reg_hub_top.sv */
/*
 * Shared register hub
 * Several AXI4-Lite managers reach one register bank
 * through a fixed-priority, transaction-locking interconnect
 */

`timescale 1ns/1ns

module reg_hub_top import axil_pkg::*; #(
  parameter int NUM_MASTERS = 3,
  parameter int NUM_REGS    = 12
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic       [NUM_MASTERS-1:0] awvalid,
  output logic       [NUM_MASTERS-1:0] awready,
  input  axil_addr_t [NUM_MASTERS-1:0] awaddr,
  input  logic       [NUM_MASTERS-1:0] wvalid,
  output logic       [NUM_MASTERS-1:0] wready,
  input  axil_data_t [NUM_MASTERS-1:0] wdata,
  input  axil_strb_t [NUM_MASTERS-1:0] wstrb,
  output logic       [NUM_MASTERS-1:0] bvalid,
  input  logic       [NUM_MASTERS-1:0] bready,
  output axil_resp_e [NUM_MASTERS-1:0] bresp,
  input  logic       [NUM_MASTERS-1:0] arvalid,
  output logic       [NUM_MASTERS-1:0] arready,
  input  axil_addr_t [NUM_MASTERS-1:0] araddr,
  output logic       [NUM_MASTERS-1:0] rvalid,
  input  logic       [NUM_MASTERS-1:0] rready,
  output axil_data_t [NUM_MASTERS-1:0] rdata,
  output axil_resp_e [NUM_MASTERS-1:0] rresp
);

  // --------------------
  // Shared subordinate port
  // --------------------
  logic       s_awvalid;
  logic       s_awready;
  axil_addr_t s_awaddr;
  logic       s_wvalid;
  logic       s_wready;
  axil_data_t s_wdata;
  axil_strb_t s_wstrb;
  logic       s_bvalid;
  logic       s_bready;
  axil_resp_e s_bresp;
  logic       s_arvalid;
  logic       s_arready;
  axil_addr_t s_araddr;
  logic       s_rvalid;
  logic       s_rready;
  axil_data_t s_rdata;
  axil_resp_e s_rresp;

  // Interconnect, managers in and one port out
  axil_arb_mux #(
    .NUM_MASTERS(NUM_MASTERS)
  ) u_mux (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_awaddr  (s_awaddr),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_bresp   (s_bresp),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_araddr  (s_araddr),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp)
  );

  // Register file behind the interconnect
  reg_bank #(
    .NUM_REGS(NUM_REGS)
  ) u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (s_awvalid),
    .awready (s_awready),
    .awaddr  (s_awaddr),
    .wvalid  (s_wvalid),
    .wready  (s_wready),
    .wdata   (s_wdata),
    .wstrb   (s_wstrb),
    .bvalid  (s_bvalid),
    .bready  (s_bready),
    .bresp   (s_bresp),
    .arvalid (s_arvalid),
    .arready (s_arready),
    .araddr  (s_araddr),
    .rvalid  (s_rvalid),
    .rready  (s_rready),
    .rdata   (s_rdata),
    .rresp   (s_rresp)
  );

endmodule

/* src/regmap_pkg.sv */
/*
 * Register map of the shared register bank
 * Index field of the byte address, ID word and reset value
 */

package regmap_pkg;

  // Register index sits just above the byte offset
  localparam int REG_IDX_LSB = 2;
  localparam int REG_IDX_W = 4;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Read-only identification word at index 0
  localparam axil_pkg::axil_data_t ID_VALUE = 32'h5245_4748;
  // Every writable register comes out of reset with this
  localparam axil_pkg::axil_data_t REG_RESET = '0;

  // Word index taken from a byte address
  function automatic reg_idx_t addr_idx(axil_pkg::axil_addr_t addr);
    return addr[REG_IDX_LSB +: REG_IDX_W];
  endfunction

  // High when no address bit above the index field is set
  function automatic logic addr_in_map(axil_pkg::axil_addr_t addr);
    return (addr >> (REG_IDX_LSB + REG_IDX_W)) == '0;
  endfunction

endpackage
